/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - source/lsu_pkg.sv
      - source/lsu_decode.sv
      - source/lsu_execute.sv
      - source/lsu_dcache.sv
      - source/lsu_result.sv
      - source/lsu_top.sv
  - target: simulation
    files:
      - sim/lsu_asserts.sv
      - sim/lsu_tb.sv

/* flist.f */
source/lsu_pkg.sv
source/lsu_decode.sv
source/lsu_execute.sv
source/lsu_dcache.sv
source/lsu_result.sv
source/lsu_top.sv
sim/lsu_asserts.sv
sim/lsu_tb.sv

/* sim/lsu_asserts.sv */
module lsu_asserts #(
    parameter int unsigned DCACHE_LINES = 16,
    parameter int unsigned LINE_WORDS   = 4,
    parameter int unsigned MISS_LATENCY = 3
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               valid_i,
    input  lsu_pkg::bus32_t    pc_i,
    input  lsu_pkg::aluop_t    aluop_i,
    input  lsu_pkg::bus32_t    base_i,
    input  lsu_pkg::bus32_t    offset_i,
    input  lsu_pkg::bus32_t    store_data_i,
    input  lsu_pkg::bus32_t    pass_data_i,
    input  lsu_pkg::reg_addr_t rd_i,
    input  logic               reg_we_i,
    input  logic               pause_i,
    input  logic               result_valid_i,
    input  logic               wb_we_i,
    input  lsu_pkg::reg_addr_t reg_addr_i,
    input  lsu_pkg::bus32_t    reg_data_i,
    input  lsu_pkg::bus32_t    commit_pc_i,
    input  logic               exception_i,
    input  lsu_pkg::ecode_t    ecode_i
);
    import lsu_pkg::*;

    localparam int OFF_W = $clog2(LINE_WORDS);

    int unsigned err_cnt = 0;

    // reference copy of the mem-stage instruction
    logic        m_valid;
    logic        m_first;
    aluop_t      m_op;
    bus32_t      m_addr;
    bus32_t      m_data;
    bus32_t      m_pass;
    bus32_t      m_pc;
    reg_addr_t   m_rd;
    logic        m_we;

    logic        m_load;
    logic        m_store;
    logic        m_half;
    logic        m_word;
    logic        m_fault;
    logic        m_access;
    logic        m_hit;
    bus32_t      m_line;
    int unsigned m_idx;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    bus32_t      exp_load;

    // byte-wide shadow of the 256-byte test region, plus line residency
    logic [7:0]  shadow [256];
    logic        line_valid [DCACHE_LINES];
    bus32_t      line_tag [DCACHE_LINES];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            m_valid <= 1'b0;
            m_first <= 1'b0;
            m_op    <= '0;
        end else begin
            m_first <= !pause_i;
            if (!pause_i) begin
                m_valid <= valid_i;
                m_op    <= aluop_i;
                m_addr  <= base_i + offset_i;
                m_data  <= store_data_i;
                m_pass  <= pass_data_i;
                m_pc    <= pc_i;
                m_rd    <= rd_i;
                m_we    <= reg_we_i;
            end
        end
    end

    always_comb begin
        m_load   = (m_op == ALU_LDB) || (m_op == ALU_LDBU) || (m_op == ALU_LDH) ||
                   (m_op == ALU_LDHU) || (m_op == ALU_LDW);
        m_store  = (m_op == ALU_STB) || (m_op == ALU_STH) || (m_op == ALU_STW);
        m_half   = (m_op == ALU_LDH) || (m_op == ALU_LDHU) || (m_op == ALU_STH);
        m_word   = (m_op == ALU_LDW) || (m_op == ALU_STW);
        m_fault  = (m_load || m_store) &&
                   ((m_half && m_addr[0]) || (m_word && (m_addr[1:0] != 2'b00)));
        m_access = m_valid && (m_load || m_store) && !m_fault;
        m_line   = m_addr >> (2 + OFF_W);
        m_idx    = m_line % DCACHE_LINES;
        m_hit    = line_valid[m_idx] && (line_tag[m_idx] == m_line);
        sel_byte = shadow[m_addr[7:0]];
        sel_half = {shadow[{m_addr[7:1], 1'b1}], shadow[{m_addr[7:1], 1'b0}]};
        case (m_op)
            ALU_LDB:  exp_load = {{24{sel_byte[7]}}, sel_byte};
            ALU_LDBU: exp_load = {24'b0, sel_byte};
            ALU_LDH:  exp_load = {{16{sel_half[15]}}, sel_half};
            ALU_LDHU: exp_load = {16'b0, sel_half};
            default: begin
                exp_load = {shadow[{m_addr[7:2], 2'd3}], shadow[{m_addr[7:2], 2'd2}],
                            shadow[{m_addr[7:2], 2'd1}], shadow[{m_addr[7:2], 2'd0}]};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 256; i++) begin
                shadow[i] <= '0;
            end
            for (int l = 0; l < DCACHE_LINES; l++) begin
                line_valid[l] <= 1'b0;
            end
        end else if (result_valid_i && m_access) begin
            line_valid[m_idx] <= 1'b1;
            line_tag[m_idx]   <= m_line;
            if (m_store) begin
                shadow[m_addr[7:0]] <= m_data[7:0];
                if (m_half || m_word) begin
                    shadow[m_addr[7:0] + 8'd1] <= m_data[15:8];
                end
                if (m_word) begin
                    shadow[m_addr[7:0] + 8'd2] <= m_data[23:16];
                    shadow[m_addr[7:0] + 8'd3] <= m_data[31:24];
                end
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        $fell(rst_i) |-> !pause_i && !result_valid_i && !wb_we_i && !exception_i)
        else begin
            $error("FAIL %0t: outputs not quiet after reset", $time);
            err_cnt++;
        end

    a_no_valid_in_pause: assert property (@(posedge clk) disable iff (rst_i)
        !(result_valid_i && pause_i))
        else begin
            $error("FAIL %0t: result_valid_o high while pause_o is high", $time);
            err_cnt++;
        end

    a_idle_quiet: assert property (@(posedge clk) disable iff (rst_i)
        !m_valid |-> !result_valid_i && !pause_i)
        else begin
            $error("FAIL %0t: result or pause with an empty mem stage", $time);
            err_cnt++;
        end

    // non-memory ops and faults finish in their first mem cycle
    a_fast_path: assert property (@(posedge clk) disable iff (rst_i)
        m_valid && !m_access |-> result_valid_i && !pause_i)
        else begin
            $error("FAIL %0t: non-cache op did not complete at once", $time);
            err_cnt++;
        end

    a_hit_no_pause: assert property (@(posedge clk) disable iff (rst_i)
        m_first && m_access && m_hit |-> result_valid_i && !pause_i)
        else begin
            $error("FAIL %0t: access to a resident line paused", $time);
            err_cnt++;
        end

    a_miss_timing: assert property (@(posedge clk) disable iff (rst_i)
        m_first && m_access && !m_hit |->
            pause_i [* MISS_LATENCY] ##1 (result_valid_i && !pause_i))
        else begin
            $error("FAIL %0t: miss pause length differs from %0d", $time, MISS_LATENCY);
            err_cnt++;
        end

    a_commit_fields: assert property (@(posedge clk) disable iff (rst_i)
        result_valid_i |-> (commit_pc_i == m_pc) && (reg_addr_i == m_rd) &&
                           (wb_we_i == (m_we && !m_fault)))
        else begin
            $error("FAIL %0t: pc %h rd %0d we %b, expected pc %h rd %0d", $time,
                   $sampled(commit_pc_i), $sampled(reg_addr_i), $sampled(wb_we_i),
                   $sampled(m_pc), $sampled(m_rd));
            err_cnt++;
        end

    a_fault: assert property (@(posedge clk) disable iff (rst_i)
        result_valid_i |-> (exception_i == m_fault) && (!m_fault || ecode_i == ECODE_ALE))
        else begin
            $error("FAIL %0t: exception %b ecode %h, expected exception %b", $time,
                   $sampled(exception_i), $sampled(ecode_i), $sampled(m_fault));
            err_cnt++;
        end

    a_pass_data: assert property (@(posedge clk) disable iff (rst_i)
        result_valid_i && !m_load && !m_store |-> reg_data_i == m_pass)
        else begin
            $error("FAIL %0t: pass data %h, expected %h", $time,
                   $sampled(reg_data_i), $sampled(m_pass));
            err_cnt++;
        end

    a_load_data: assert property (@(posedge clk) disable iff (rst_i)
        result_valid_i && m_load && !m_fault |-> reg_data_i == exp_load)
        else begin
            $error("FAIL %0t: load op %h addr %h data %h, expected %h", $time,
                   $sampled(m_op), $sampled(m_addr), $sampled(reg_data_i),
                   $sampled(exp_load));
            err_cnt++;
        end

endmodule

bind lsu_top lsu_asserts #(
    .DCACHE_LINES (DCACHE_LINES),
    .LINE_WORDS   (LINE_WORDS),
    .MISS_LATENCY (MISS_LATENCY)
) u_lsu_asserts (
    .clk            (clk),
    .rst_i          (rst_i),
    .valid_i        (valid_i),
    .pc_i           (pc_i),
    .aluop_i        (aluop_i),
    .base_i         (base_i),
    .offset_i       (offset_i),
    .store_data_i   (store_data_i),
    .pass_data_i    (pass_data_i),
    .rd_i           (rd_i),
    .reg_we_i       (reg_we_i),
    .pause_i        (pause_o),
    .result_valid_i (result_valid_o),
    .wb_we_i        (reg_we_o),
    .reg_addr_i     (reg_addr_o),
    .reg_data_i     (reg_data_o),
    .commit_pc_i    (commit_pc_o),
    .exception_i    (exception_o),
    .ecode_i        (ecode_o)
);

/* sim/lsu_tb.sv */
module lsu_tb;
    import lsu_pkg::*;

    localparam int unsigned CLK_PERIOD   = 4;
    localparam int unsigned MISS_LATENCY = 3;
    localparam int unsigned N_RANDOM     = 200;
    // directed tests issue 2, 3, 14 and 6 instructions
    localparam int unsigned N_ISSUED        = 2 + 3 + 14 + 6 + N_RANDOM;
    localparam int unsigned WATCHDOG_CYCLES = N_ISSUED * (MISS_LATENCY + 2) + 100;

    logic      clk = 1'b0;
    logic      rst_i;
    logic      valid_i;
    bus32_t    pc_i;
    aluop_t    aluop_i;
    bus32_t    base_i;
    bus32_t    offset_i;
    bus32_t    store_data_i;
    bus32_t    pass_data_i;
    reg_addr_t rd_i;
    logic      reg_we_i;

    logic      pause_o;
    logic      result_valid_o;
    logic      reg_we_o;
    reg_addr_t reg_addr_o;
    bus32_t    reg_data_o;
    bus32_t    commit_pc_o;
    logic      exception_o;
    ecode_t    ecode_o;

    int unsigned num_tests;
    int unsigned start_errors;
    int unsigned total_errors;
    bus32_t      next_pc;

    always #(CLK_PERIOD / 2) clk = ~clk;

    lsu_top #(
        .DCACHE_LINES (4),
        .LINE_WORDS   (4),
        .MISS_LATENCY (MISS_LATENCY)
    ) u_lsu_top (
        .clk            (clk),
        .rst_i          (rst_i),
        .valid_i        (valid_i),
        .pc_i           (pc_i),
        .aluop_i        (aluop_i),
        .base_i         (base_i),
        .offset_i       (offset_i),
        .store_data_i   (store_data_i),
        .pass_data_i    (pass_data_i),
        .rd_i           (rd_i),
        .reg_we_i       (reg_we_i),
        .pause_o        (pause_o),
        .result_valid_o (result_valid_o),
        .reg_we_o       (reg_we_o),
        .reg_addr_o     (reg_addr_o),
        .reg_data_o     (reg_data_o),
        .commit_pc_o    (commit_pc_o),
        .exception_o    (exception_o),
        .ecode_o        (ecode_o)
    );

    // present one instruction and hold it until an unpaused edge takes it
    task automatic issue(input aluop_t op, input bus32_t addr, input bus32_t data);
        bus32_t off;
        logic   taken;
        off          = $urandom_range(0, 255);
        valid_i      = 1'b1;
        pc_i         = next_pc;
        aluop_i      = op;
        base_i       = addr - off;
        offset_i     = off;
        store_data_i = data;
        pass_data_i  = $urandom;
        rd_i         = reg_addr_t'($urandom_range(1, 31));
        reg_we_i     = 1'($urandom_range(0, 1));
        next_pc      = next_pc + 32'd4;
        do begin
            @(negedge clk);
            taken = !pause_o;
            @(posedge clk);
            #1;
        end while (!taken);
    endtask

    // let the last instruction leave the mem stage
    task automatic drain();
        valid_i = 1'b0;
        aluop_i = '0;
        do begin
            @(negedge clk);
        end while (pause_o);
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        int unsigned errs;
        drain();
        errs = u_lsu_top.u_lsu_asserts.err_cnt - start_errors;
        num_tests++;
        $display("[%0t] %0d %-24s assertion failures %0d", $time, num_tests, name, errs);
        start_errors = u_lsu_top.u_lsu_asserts.err_cnt;
    endtask

    task automatic random_access();
        aluop_t      op;
        bus32_t      addr;
        int unsigned pick;
        pick = $urandom_range(0, 7);
        case (pick)
            0: op = ALU_STB;
            1: op = ALU_STH;
            2: op = ALU_STW;
            3: op = ALU_LDB;
            4: op = ALU_LDBU;
            5: op = ALU_LDH;
            6: op = ALU_LDHU;
            default: op = ALU_LDW;
        endcase
        // 256-byte region is four times the cache size
        addr = $urandom_range(0, 255);
        if (op == ALU_STH || op == ALU_LDH || op == ALU_LDHU) begin
            addr[0] = 1'b0;
        end
        if (op == ALU_STW || op == ALU_LDW) begin
            addr[1:0] = 2'b00;
        end
        issue(op, addr, $urandom);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
                 WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h8381));
        rst_i        = 1'b1;
        valid_i      = 1'b0;
        pc_i         = '0;
        aluop_i      = '0;
        base_i       = '0;
        offset_i     = '0;
        store_data_i = '0;
        pass_data_i  = '0;
        rd_i         = '0;
        reg_we_i     = 1'b0;
        num_tests    = 0;
        start_errors = 0;
        next_pc      = 32'h1c00_0000;
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;

        issue(8'h00, 32'h0, 32'h0);
        issue(8'h1f, 32'h0, 32'h0);
        finish_test("reset_pass_through");

        issue(ALU_LDW, 32'h40, 32'h0);
        issue(ALU_LDW, 32'h44, 32'h0);
        issue(ALU_LDBU, 32'h4e, 32'h0);
        finish_test("miss_then_hit");

        // bytes of mixed sign
        issue(ALU_STW, 32'h80, 32'hf18c_7a05);
        for (int b = 0; b < 4; b++) begin
            issue(ALU_LDB, 32'h80 + b, 32'h0);
        end
        for (int b = 0; b < 4; b++) begin
            issue(ALU_LDBU, 32'h80 + b, 32'h0);
        end
        issue(ALU_LDH, 32'h80, 32'h0);
        issue(ALU_LDH, 32'h82, 32'h0);
        issue(ALU_LDHU, 32'h80, 32'h0);
        issue(ALU_LDHU, 32'h82, 32'h0);
        issue(ALU_LDW, 32'h80, 32'h0);
        finish_test("sub_word_loads");

        issue(ALU_STW, 32'h90, 32'h1234_5678);
        issue(ALU_LDH, 32'h91, 32'h0);
        issue(ALU_LDW, 32'h92, 32'h0);
        issue(ALU_STW, 32'h91, 32'hffff_ffff);
        issue(ALU_STH, 32'h93, 32'hffff_ffff);
        issue(ALU_LDW, 32'h90, 32'h0);
        finish_test("misaligned_fault");

        for (int n = 0; n < N_RANDOM; n++) begin
            random_access();
        end
        finish_test("random_mix");

        total_errors = u_lsu_top.u_lsu_asserts.err_cnt;
        $display("tests run %0d, assertion failures %0d", num_tests, total_errors);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* source/lsu_dcache.sv */
module lsu_dcache #(
    parameter int unsigned DCACHE_LINES = 16,
    parameter int unsigned LINE_WORDS   = 4,
    parameter int unsigned MISS_LATENCY = 3
) (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            req_i,
    input  logic            we_i,
    input  lsu_pkg::bus32_t addr_i,
    input  logic [3:0]      byte_en_i,
    input  lsu_pkg::bus32_t wdata_i,
    output logic            data_ok_o,
    output lsu_pkg::bus32_t rdata_o
);
    import lsu_pkg::*;

    localparam int OFF_W    = $clog2(LINE_WORDS);
    localparam int IDX_W    = $clog2(DCACHE_LINES);
    localparam int IDX_BITS = (IDX_W > 0) ? IDX_W : 1;
    localparam int TAG_W    = 30 - OFF_W - IDX_W;
    localparam int CNT_W    = $clog2(MISS_LATENCY) + 1;
    // local store spans four cache-sized pages, higher address bits alias
    localparam int MEM_PAGES = 4;
    localparam int MEM_WORDS = DCACHE_LINES * LINE_WORDS * MEM_PAGES;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    dcache_state_e           state_q;
    logic [CNT_W-1:0]        cnt_q;
    logic [DCACHE_LINES-1:0] line_valid_q;
    logic [TAG_W-1:0]        tag_q [DCACHE_LINES];
    bus32_t                  data_q [MEM_WORDS];

    logic [29:0]       word_addr;
    logic [29:0]       line_addr;
    logic [IDX_BITS-1:0] idx;
    logic [TAG_W-1:0]  tag;
    logic [MEM_AW-1:0] mem_idx;
    logic              hit;
    logic              refill_done;

    assign word_addr = addr_i[31:2];
    assign line_addr = word_addr >> OFF_W;
    assign idx       = IDX_BITS'(line_addr % DCACHE_LINES);
    assign tag       = TAG_W'(line_addr >> IDX_W);
    assign mem_idx   = MEM_AW'(word_addr);

    assign hit         = line_valid_q[idx] && (tag_q[idx] == tag);
    assign refill_done = (state_q == DC_REFILL) && (cnt_q == CNT_W'(MISS_LATENCY - 1));

    assign data_ok_o = req_i && (((state_q == DC_IDLE) && hit) || refill_done);
    assign rdata_o   = data_q[mem_idx];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= DC_IDLE;
            cnt_q        <= '0;
            line_valid_q <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                data_q[i] <= '0;
            end
        end else begin
            case (state_q)
                DC_IDLE: begin
                    if (req_i && !hit) begin
                        state_q <= DC_REFILL;
                        cnt_q   <= '0;
                    end
                end
                DC_REFILL: begin
                    if (refill_done) begin
                        line_valid_q[idx] <= 1'b1;
                        state_q           <= DC_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= DC_IDLE;
            endcase
            // store lands on a hit or in the last refill cycle
            if (data_ok_o && we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (byte_en_i[b]) begin
                        data_q[mem_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_q[idx] <= tag;
        end
    end

endmodule

/* source/lsu_decode.sv */
module lsu_decode (
    input  lsu_pkg::aluop_t    aluop_i,
    output logic               is_load_o,
    output logic               is_store_o,
    output lsu_pkg::mem_size_e size_o,
    output logic               sign_ext_o
);
    import lsu_pkg::*;

    always_comb begin
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        size_o     = SIZE_W;
        sign_ext_o = 1'b0;
        case (aluop_i)
            ALU_LDB: begin
                is_load_o  = 1'b1;
                size_o     = SIZE_B;
                sign_ext_o = 1'b1;
            end
            ALU_LDBU: begin
                is_load_o = 1'b1;
                size_o    = SIZE_B;
            end
            ALU_LDH: begin
                is_load_o  = 1'b1;
                size_o     = SIZE_H;
                sign_ext_o = 1'b1;
            end
            ALU_LDHU: begin
                is_load_o = 1'b1;
                size_o    = SIZE_H;
            end
            ALU_LDW: begin
                is_load_o = 1'b1;
                size_o    = SIZE_W;
            end
            ALU_STB: begin
                is_store_o = 1'b1;
                size_o     = SIZE_B;
            end
            ALU_STH: begin
                is_store_o = 1'b1;
                size_o     = SIZE_H;
            end
            ALU_STW: begin
                is_store_o = 1'b1;
                size_o     = SIZE_W;
            end
            default: begin
                // not a memory op, result passes through
                is_load_o  = 1'b0;
                is_store_o = 1'b0;
            end
        endcase
    end

endmodule

/* source/lsu_execute.sv */
module lsu_execute (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                valid_i,
    input  lsu_pkg::bus32_t     pc_i,
    input  lsu_pkg::bus32_t     base_i,
    input  lsu_pkg::bus32_t     offset_i,
    input  lsu_pkg::bus32_t     store_data_i,
    input  lsu_pkg::bus32_t     pass_data_i,
    input  lsu_pkg::reg_addr_t  rd_i,
    input  logic                reg_we_i,
    input  logic                is_load_i,
    input  logic                is_store_i,
    input  lsu_pkg::mem_size_e  size_i,
    input  logic                sign_ext_i,
    input  logic                pause_i,
    output logic                req_o,
    output logic                we_o,
    output lsu_pkg::bus32_t     addr_o,
    output logic [3:0]          byte_en_o,
    output lsu_pkg::bus32_t     wdata_o,
    output logic                mem_valid_o,
    output logic                mem_is_load_o,
    output logic                mem_is_store_o,
    output lsu_pkg::mem_size_e  mem_size_o,
    output logic                mem_sign_ext_o,
    output lsu_pkg::bus32_t     mem_addr_o,
    output lsu_pkg::bus32_t     mem_pc_o,
    output lsu_pkg::bus32_t     mem_pass_data_o,
    output lsu_pkg::reg_addr_t  mem_rd_o,
    output logic                mem_reg_we_o,
    output logic                mem_exception_o
);
    import lsu_pkg::*;

    bus32_t     ex_addr;
    logic       misaligned;
    logic [3:0] ex_byte_en;
    bus32_t     ex_wdata;

    bus32_t     addr_q;
    bus32_t     pc_q;
    bus32_t     pass_data_q;
    bus32_t     wdata_q;
    logic [3:0] byte_en_q;
    reg_addr_t  rd_q;
    mem_size_e  size_q;
    logic       sign_ext_q;
    logic       is_load_q;
    logic       is_store_q;
    logic       valid_q;
    logic       reg_we_q;
    logic       exception_q;

    assign ex_addr = base_i + offset_i;

    assign misaligned = ((size_i == SIZE_H) && ex_addr[0]) ||
                        ((size_i == SIZE_W) && (ex_addr[1:0] != 2'b00));

    // lane enables and replicated store data
    always_comb begin
        case (size_i)
            SIZE_B: begin
                ex_byte_en = 4'b0001 << ex_addr[1:0];
                ex_wdata   = {4{store_data_i[7:0]}};
            end
            SIZE_H: begin
                ex_byte_en = 4'b0011 << {ex_addr[1], 1'b0};
                ex_wdata   = {2{store_data_i[15:0]}};
            end
            default: begin
                ex_byte_en = 4'b1111;
                ex_wdata   = store_data_i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q     <= 1'b0;
            reg_we_q    <= 1'b0;
            exception_q <= 1'b0;
        end else if (!pause_i) begin
            valid_q     <= valid_i;
            reg_we_q    <= reg_we_i;
            exception_q <= valid_i && (is_load_i || is_store_i) && misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (!pause_i) begin
            addr_q      <= ex_addr;
            pc_q        <= pc_i;
            pass_data_q <= pass_data_i;
            wdata_q     <= ex_wdata;
            byte_en_q   <= ex_byte_en;
            rd_q        <= rd_i;
            size_q      <= size_i;
            sign_ext_q  <= sign_ext_i;
            is_load_q   <= is_load_i;
            is_store_q  <= is_store_i;
        end
    end

    // a faulting access never reaches the cache
    assign req_o     = valid_q && (is_load_q || is_store_q) && !exception_q;
    assign we_o      = is_store_q;
    assign addr_o    = addr_q;
    assign byte_en_o = byte_en_q;
    assign wdata_o   = wdata_q;

    assign mem_valid_o     = valid_q;
    assign mem_is_load_o   = is_load_q;
    assign mem_is_store_o  = is_store_q;
    assign mem_size_o      = size_q;
    assign mem_sign_ext_o  = sign_ext_q;
    assign mem_addr_o      = addr_q;
    assign mem_pc_o        = pc_q;
    assign mem_pass_data_o = pass_data_q;
    assign mem_rd_o        = rd_q;
    assign mem_reg_we_o    = reg_we_q;
    assign mem_exception_o = exception_q;

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [5:0]  ecode_t;

    // loads
    localparam aluop_t ALU_LDB  = 8'h40;
    localparam aluop_t ALU_LDH  = 8'h41;
    localparam aluop_t ALU_LDW  = 8'h42;
    localparam aluop_t ALU_LDBU = 8'h44;
    localparam aluop_t ALU_LDHU = 8'h45;

    // stores
    localparam aluop_t ALU_STB  = 8'h48;
    localparam aluop_t ALU_STH  = 8'h49;
    localparam aluop_t ALU_STW  = 8'h4a;

    // address not aligned to access size
    localparam ecode_t ECODE_ALE = 6'h09;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    typedef enum logic {
        DC_IDLE   = 1'b0,
        DC_REFILL = 1'b1
    } dcache_state_e;

endpackage

/* source/lsu_result.sv */
module lsu_result (
    input  logic               mem_valid_i,
    input  logic               mem_is_load_i,
    input  logic               mem_is_store_i,
    input  lsu_pkg::mem_size_e mem_size_i,
    input  logic               mem_sign_ext_i,
    input  lsu_pkg::bus32_t    mem_addr_i,
    input  lsu_pkg::bus32_t    mem_pc_i,
    input  lsu_pkg::bus32_t    mem_pass_data_i,
    input  lsu_pkg::reg_addr_t mem_rd_i,
    input  logic               mem_reg_we_i,
    input  logic               mem_exception_i,
    input  logic               data_ok_i,
    input  lsu_pkg::bus32_t    rdata_i,
    output logic               pause_o,
    output logic               result_valid_o,
    output logic               reg_we_o,
    output lsu_pkg::reg_addr_t reg_addr_o,
    output lsu_pkg::bus32_t    reg_data_o,
    output lsu_pkg::bus32_t    commit_pc_o,
    output logic               exception_o,
    output lsu_pkg::ecode_t    ecode_o
);
    import lsu_pkg::*;

    bus32_t      cache_data;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    bus32_t      load_data;

    assign cache_data = data_ok_i ? rdata_i : 32'b0;

    // lane picked by the low address bits
    assign byte_lane = cache_data[{mem_addr_i[1:0], 3'b000} +: 8];
    assign half_lane = mem_addr_i[1] ? cache_data[31:16] : cache_data[15:0];

    always_comb begin
        case (mem_size_i)
            SIZE_B: begin
                load_data = {{24{mem_sign_ext_i & byte_lane[7]}}, byte_lane};
            end
            SIZE_H: begin
                load_data = {{16{mem_sign_ext_i & half_lane[15]}}, half_lane};
            end
            default: begin
                load_data = cache_data;
            end
        endcase
    end

    // hold upstream until the cache answers
    assign pause_o = mem_valid_i && (mem_is_load_i || mem_is_store_i) &&
                     !mem_exception_i && !data_ok_i;

    assign result_valid_o = mem_valid_i && !pause_o;
    assign reg_we_o       = result_valid_o && mem_reg_we_i && !mem_exception_i;
    assign reg_addr_o     = mem_rd_i;
    assign reg_data_o     = mem_is_load_i ? load_data : mem_pass_data_i;
    assign commit_pc_o    = mem_pc_i;
    assign exception_o    = mem_valid_i && mem_exception_i;
    assign ecode_o        = mem_exception_i ? ECODE_ALE : '0;

endmodule

/* source/lsu_top.sv */
module lsu_top #(
    parameter int unsigned DCACHE_LINES = 16,
    parameter int unsigned LINE_WORDS   = 4,
    parameter int unsigned MISS_LATENCY = 3
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               valid_i,
    input  lsu_pkg::bus32_t    pc_i,
    input  lsu_pkg::aluop_t    aluop_i,
    input  lsu_pkg::bus32_t    base_i,
    input  lsu_pkg::bus32_t    offset_i,
    input  lsu_pkg::bus32_t    store_data_i,
    input  lsu_pkg::bus32_t    pass_data_i,
    input  lsu_pkg::reg_addr_t rd_i,
    input  logic               reg_we_i,
    output logic               pause_o,
    output logic               result_valid_o,
    output logic               reg_we_o,
    output lsu_pkg::reg_addr_t reg_addr_o,
    output lsu_pkg::bus32_t    reg_data_o,
    output lsu_pkg::bus32_t    commit_pc_o,
    output logic               exception_o,
    output lsu_pkg::ecode_t    ecode_o
);
    import lsu_pkg::*;

    logic       is_load;
    logic       is_store;
    mem_size_e  size;
    logic       sign_ext;

    logic       req;
    logic       we;
    bus32_t     addr;
    logic [3:0] byte_en;
    bus32_t     wdata;
    logic       data_ok;
    bus32_t     rdata;

    logic       mem_valid;
    logic       mem_is_load;
    logic       mem_is_store;
    mem_size_e  mem_size;
    logic       mem_sign_ext;
    bus32_t     mem_addr;
    bus32_t     mem_pc;
    bus32_t     mem_pass_data;
    reg_addr_t  mem_rd;
    logic       mem_reg_we;
    logic       mem_exception;

    lsu_decode u_decode (
        .aluop_i    (aluop_i),
        .is_load_o  (is_load),
        .is_store_o (is_store),
        .size_o     (size),
        .sign_ext_o (sign_ext)
    );

    lsu_execute u_execute (
        .clk             (clk),
        .rst_i           (rst_i),
        .valid_i         (valid_i),
        .pc_i            (pc_i),
        .base_i          (base_i),
        .offset_i        (offset_i),
        .store_data_i    (store_data_i),
        .pass_data_i     (pass_data_i),
        .rd_i            (rd_i),
        .reg_we_i        (reg_we_i),
        .is_load_i       (is_load),
        .is_store_i      (is_store),
        .size_i          (size),
        .sign_ext_i      (sign_ext),
        .pause_i         (pause_o),
        .req_o           (req),
        .we_o            (we),
        .addr_o          (addr),
        .byte_en_o       (byte_en),
        .wdata_o         (wdata),
        .mem_valid_o     (mem_valid),
        .mem_is_load_o   (mem_is_load),
        .mem_is_store_o  (mem_is_store),
        .mem_size_o      (mem_size),
        .mem_sign_ext_o  (mem_sign_ext),
        .mem_addr_o      (mem_addr),
        .mem_pc_o        (mem_pc),
        .mem_pass_data_o (mem_pass_data),
        .mem_rd_o        (mem_rd),
        .mem_reg_we_o    (mem_reg_we),
        .mem_exception_o (mem_exception)
    );

    lsu_dcache #(
        .DCACHE_LINES (DCACHE_LINES),
        .LINE_WORDS   (LINE_WORDS),
        .MISS_LATENCY (MISS_LATENCY)
    ) u_dcache (
        .clk       (clk),
        .rst_i     (rst_i),
        .req_i     (req),
        .we_i      (we),
        .addr_i    (addr),
        .byte_en_i (byte_en),
        .wdata_i   (wdata),
        .data_ok_o (data_ok),
        .rdata_o   (rdata)
    );

    lsu_result u_result (
        .mem_valid_i     (mem_valid),
        .mem_is_load_i   (mem_is_load),
        .mem_is_store_i  (mem_is_store),
        .mem_size_i      (mem_size),
        .mem_sign_ext_i  (mem_sign_ext),
        .mem_addr_i      (mem_addr),
        .mem_pc_i        (mem_pc),
        .mem_pass_data_i (mem_pass_data),
        .mem_rd_i        (mem_rd),
        .mem_reg_we_i    (mem_reg_we),
        .mem_exception_i (mem_exception),
        .data_ok_i       (data_ok),
        .rdata_i         (rdata),
        .pause_o         (pause_o),
        .result_valid_o  (result_valid_o),
        .reg_we_o        (reg_we_o),
        .reg_addr_o      (reg_addr_o),
        .reg_data_o      (reg_data_o),
        .commit_pc_o     (commit_pc_o),
        .exception_o     (exception_o),
        .ecode_o         (ecode_o)
    );

endmodule
